//--- Makefile
TOP = tbDcache

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- dcache.f
dcachePkg.sv
dcacheCtrl.sv
tagStore.sv
lineDataArray.sv
refillBuffer.sv
dcacheTop.sv
tbMemPort.sv
tbDcache.sv

//--- dcacheCtrl.sv
`timescale 1ns/1ps

module dcacheCtrl import dcachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reqValid_i,
  input  logic     reqWrite_i,
  input  addr_t    addr_i,
  input  word_t    wrData_i,
  input  mask_t    wrMask_i,
  input  logic     hitWay0_i,
  input  logic     hitWay1_i,
  input  logic     victimDirty_i,
  input  logic     rdReady_i,
  input  logic     dataValid_i,
  input  logic     rdLast_i,
  input  logic     wrReady_i,
  output tag_t     reqTag_o,
  output index_t   reqIndex_o,
  output wordSel_t reqWordSel_o,
  output word_t    storeData_o,
  output mask_t    storeMask_o,
  output logic     victimWay_o,
  output logic     storeWr_o,
  output logic     lineFill_o,
  output logic     tagUpdate_o,
  output logic     beatEn_o,
  output logic     addrOk_o,
  output logic     dataOk_o,
  output logic     rdValid_o,
  output logic     wrValid_o
);

  cacheState_t curState;
  cacheState_t nextState;
  logic        reqWrite;
  logic        toggleBit;
  logic        chosenWay;
  logic        cacheHit;
  logic        accept;
  logic        compareMiss;

  assign cacheHit    = hitWay0_i || hitWay1_i;
  assign addrOk_o    = (curState == IDLE) || (curState == COMPARE && cacheHit);
  assign accept      = reqValid_i && addrOk_o;
  assign compareMiss = (curState == COMPARE) && !cacheHit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= IDLE;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    unique case (curState)
      IDLE: begin
        if (accept) nextState = COMPARE;
      end
      COMPARE: begin
        if (cacheHit) begin
          nextState = accept ? COMPARE : IDLE;
        end else begin
          // dirty victim goes out before the refill read
          nextState = victimDirty_i ? WRBACK : MISS;
        end
      end
      WRBACK: begin
        if (wrReady_i) nextState = MISS;
      end
      MISS: begin
        if (rdReady_i) nextState = GETDATA;
      end
      GETDATA: begin
        if (dataValid_i && rdLast_i) nextState = REPLACE;
      end
      REPLACE: nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWrite <= 1'b0;
    end else if (accept) begin
      reqWrite <= reqWrite_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqTag_o     <= addr_i[ADDR_W-1 -: TAG_W];
      reqIndex_o   <= addr_i[OFFSET_W +: INDEX_W];
      reqWordSel_o <= addr_i[OFFSET_W-1 -: WORDSEL_W];
      storeData_o  <= wrData_i;
      storeMask_o  <= wrMask_i;
    end
  end

  // victim way flips on every miss and holds until the refill ends
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      toggleBit <= 1'b0;
      chosenWay <= 1'b0;
    end else if (compareMiss) begin
      toggleBit <= ~toggleBit;
      chosenWay <= toggleBit;
    end
  end

  assign victimWay_o = (curState == COMPARE) ? toggleBit : chosenWay;

  assign dataOk_o    = (curState == COMPARE) && cacheHit;
  assign storeWr_o   = dataOk_o && reqWrite;
  assign beatEn_o    = (curState == GETDATA) && dataValid_i;
  assign tagUpdate_o = beatEn_o && rdLast_i;
  assign lineFill_o  = (curState == REPLACE);
  assign rdValid_o   = (curState == MISS);
  assign wrValid_o   = (curState == WRBACK);

  // a write-back only goes out for a dirty victim
  aWbDirty: assert property (@(posedge clk) disable iff (!rst_n)
    wrValid_o |-> victimDirty_i);

  // the compare after a refill always hits
  aRefillHit: assert property (@(posedge clk) disable iff (!rst_n)
    lineFill_o |=> dataOk_o);

endmodule

//--- dcachePkg.sv
package dcachePkg;

  // address and data geometry
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 64;
  localparam int NUM_SETS       = 64;
  localparam int NUM_WAYS       = 2;
  localparam int BEATS_PER_LINE = 4;
  localparam int OFFSET_W       = 5;

  localparam int INDEX_W   = $clog2(NUM_SETS);
  localparam int WORDSEL_W = $clog2(BEATS_PER_LINE);
  localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [ADDR_W-1:0]                addr_t;
  typedef logic [WORD_W-1:0]                word_t;
  typedef logic [WORD_W/8-1:0]              mask_t;
  typedef logic [BEATS_PER_LINE*WORD_W-1:0] line_t;
  typedef logic [TAG_W-1:0]                 tag_t;
  typedef logic [INDEX_W-1:0]               index_t;
  typedef logic [WORDSEL_W-1:0]             wordSel_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRBACK,
    MISS,
    GETDATA,
    REPLACE
  } cacheState_t;

endpackage

//--- dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop import dcachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // load/store side
  input  logic     reqValid_i,
  input  logic     reqWrite_i,
  input  addr_t    addr_i,
  input  word_t    wrData_i,
  input  mask_t    wrMask_i,
  output logic     addrOk_o,
  output logic     dataOk_o,
  output word_t    rdData_o,
  // memory read side
  output logic     rdValid_o,
  output addr_t    rdAddr_o,
  input  logic     rdReady_i,
  input  word_t    memRdData_i,
  input  logic     dataValid_i,
  input  logic     rdLast_i,
  // memory write side
  output logic     wrValid_o,
  output addr_t    wrAddr_o,
  output line_t    wrData_o,
  input  logic     wrReady_i
);

  tag_t     reqTag;
  index_t   reqIndex;
  wordSel_t reqWordSel;
  word_t    storeData;
  mask_t    storeMask;
  logic     victimWay;
  logic     storeWr;
  logic     lineFill;
  logic     tagUpdate;
  logic     beatEn;
  logic     hitWay0;
  logic     hitWay1;
  logic     victimDirty;
  line_t    fillLine;

  // refill reads always start at the line base
  assign rdAddr_o = {reqTag, reqIndex, {OFFSET_W{1'b0}}};

  dcacheCtrl i_dcacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqWrite_i    (reqWrite_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .hitWay0_i     (hitWay0),
    .hitWay1_i     (hitWay1),
    .victimDirty_i (victimDirty),
    .rdReady_i     (rdReady_i),
    .dataValid_i   (dataValid_i),
    .rdLast_i      (rdLast_i),
    .wrReady_i     (wrReady_i),
    .reqTag_o      (reqTag),
    .reqIndex_o    (reqIndex),
    .reqWordSel_o  (reqWordSel),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .victimWay_o   (victimWay),
    .storeWr_o     (storeWr),
    .lineFill_o    (lineFill),
    .tagUpdate_o   (tagUpdate),
    .beatEn_o      (beatEn),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdValid_o     (rdValid_o),
    .wrValid_o     (wrValid_o)
  );

  tagStore i_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (reqIndex),
    .tag_i         (reqTag),
    .victimWay_i   (victimWay),
    .storeWr_i     (storeWr),
    .tagUpdate_i   (tagUpdate),
    .hitWay0_o     (hitWay0),
    .hitWay1_o     (hitWay1),
    .victimDirty_o (victimDirty),
    .victimAddr_o  (wrAddr_o)
  );

  lineDataArray i_lineDataArray (
    .clk          (clk),
    .index_i      (reqIndex),
    .wordSel_i    (reqWordSel),
    .hitWay1_i    (hitWay1),
    .victimWay_i  (victimWay),
    .lineFill_i   (lineFill),
    .fillLine_i   (fillLine),
    .storeWr_i    (storeWr),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .rdWord_o     (rdData_o),
    .victimLine_o (wrData_o)
  );

  refillBuffer i_refillBuffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .beatEn_i (beatEn),
    .beat_i   (memRdData_i),
    .line_o   (fillLine)
  );

endmodule

//--- lineDataArray.sv
`timescale 1ns/1ps

module lineDataArray import dcachePkg::*; (
  input  logic     clk,
  input  index_t   index_i,
  input  wordSel_t wordSel_i,
  input  logic     hitWay1_i,
  input  logic     victimWay_i,
  input  logic     lineFill_i,
  input  line_t    fillLine_i,
  input  logic     storeWr_i,
  input  word_t    storeData_i,
  input  mask_t    storeMask_i,
  output word_t    rdWord_o,
  output line_t    victimLine_o
);

  line_t lineMem [NUM_WAYS][NUM_SETS];
  line_t hitLine;
  word_t oldWord;
  word_t mergedWord;

  // combinational read of the hitting way
  assign hitLine  = lineMem[hitWay1_i][index_i];
  assign oldWord  = hitLine[wordSel_i*WORD_W +: WORD_W];
  assign rdWord_o = oldWord;

  assign victimLine_o = lineMem[victimWay_i][index_i];

  // byte merge for store hits
  always_comb begin
    mergedWord = oldWord;
    for (int b = 0; b < $bits(mask_t); b++) begin
      if (storeMask_i[b]) begin
        mergedWord[b*8 +: 8] = storeData_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lineFill_i) begin
      lineMem[victimWay_i][index_i] <= fillLine_i;
    end else if (storeWr_i) begin
      lineMem[hitWay1_i][index_i][wordSel_i*WORD_W +: WORD_W] <= mergedWord;
    end
  end

  // refill and store hit come from different controller states
  aFillOrStore: assert property (@(posedge clk)
    !(lineFill_i && storeWr_i));

endmodule

//--- refillBuffer.sv
`timescale 1ns/1ps

module refillBuffer import dcachePkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  beatEn_i,
  input  word_t beat_i,
  output line_t line_o
);

  wordSel_t beatCnt;
  line_t    lineBuf;

  // beat counter wraps to zero after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatEn_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // each beat goes to its own word slot
  always_ff @(posedge clk) begin
    if (beatEn_i) begin
      lineBuf[beatCnt*WORD_W +: WORD_W] <= beat_i;
    end
  end

  assign line_o = lineBuf;

endmodule

//--- tagStore.sv
`timescale 1ns/1ps

module tagStore import dcachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  index_t index_i,
  input  tag_t   tag_i,
  input  logic   victimWay_i,
  input  logic   storeWr_i,
  input  logic   tagUpdate_i,
  output logic   hitWay0_o,
  output logic   hitWay1_o,
  output logic   victimDirty_o,
  output addr_t  victimAddr_o
);

  tag_t                tagArr   [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] validArr [NUM_WAYS];
  logic [NUM_SETS-1:0] dirtyArr [NUM_WAYS];
  tag_t                victimTag;

  // tag compare per way
  assign hitWay0_o = validArr[0][index_i] && (tagArr[0][index_i] == tag_i);
  assign hitWay1_o = validArr[1][index_i] && (tagArr[1][index_i] == tag_i);

  assign victimTag     = tagArr[victimWay_i][index_i];
  assign victimDirty_o = validArr[victimWay_i][index_i] && dirtyArr[victimWay_i][index_i];
  assign victimAddr_o  = {victimTag, index_i, {OFFSET_W{1'b0}}};

  // new tag lands in the victim way when the last beat arrives
  always_ff @(posedge clk) begin
    if (tagUpdate_i) begin
      tagArr[victimWay_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
    end else if (tagUpdate_i) begin
      validArr[victimWay_i][index_i] <= 1'b1;
      dirtyArr[victimWay_i][index_i] <= 1'b0;
    end else if (storeWr_i) begin
      // store hit marks the hitting way
      dirtyArr[hitWay1_o][index_i] <= 1'b1;
    end
  end

  // one set never holds the same tag twice
  aOneHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(hitWay0_o && hitWay1_o));

endmodule

//--- tbDcache.sv
`timescale 1ns/1ps

module tbDcache import dcachePkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 3;
  localparam int TIMEOUT      = 200;
  localparam int NUM_RANDOM   = 200;
  localparam int MEM_WORDS    = 4096;
  localparam int IDX_W        = $clog2(MEM_WORDS);

  logic  clk;
  logic  rst_n;
  logic  reqValid_i;
  logic  reqWrite_i;
  addr_t addr_i;
  word_t wrData_i;
  mask_t wrMask_i;
  logic  addrOk_o;
  logic  dataOk_o;
  word_t rdData_o;
  logic  rdValid_o;
  addr_t rdAddr_o;
  logic  rdReady_i;
  word_t memRdData_i;
  logic  dataValid_i;
  logic  rdLast_i;
  logic  wrValid_o;
  addr_t wrAddr_o;
  line_t wrData_o;
  logic  wrReady_i;

  // what the last access saw on the outputs
  word_t lastRdData;
  int    lastCycles;
  logic  sawRdValid;
  logic  sawWrValid;
  addr_t seenRdAddr;
  addr_t seenWrAddr;
  line_t seenWrLine;

  word_t refMem [MEM_WORDS];
  int    seed;

  dcacheTop i_dcacheTop (.*);

  tbMemPort #(.MEM_WORDS(MEM_WORDS)) i_memPort (
    .clk         (clk),
    .rdValid_i   (rdValid_o),
    .rdAddr_i    (rdAddr_o),
    .wrValid_i   (wrValid_o),
    .wrAddr_i    (wrAddr_o),
    .wrData_i    (wrData_o),
    .rdReady_o   (rdReady_i),
    .memRdData_o (memRdData_i),
    .dataValid_o (dataValid_i),
    .rdLast_o    (rdLast_i),
    .wrReady_o   (wrReady_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [IDX_W-1:0] refIndex(input addr_t a);
    return a[IDX_W+2:3];
  endfunction

  function automatic word_t expandMask(input mask_t m);
    word_t bits;
    for (int b = 0; b < 8; b++) begin
      bits[b*8 +: 8] = {8{m[b]}};
    end
    return bits;
  endfunction

  // whole line as the reference memory holds it with word 0 lowest
  function automatic line_t refLine(input addr_t a);
    line_t l;
    for (int b = 0; b < BEATS_PER_LINE; b++) begin
      l[b*WORD_W +: WORD_W] = refMem[refIndex({a[31:5], wordSel_t'(b), 3'b000})];
    end
    return l;
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkValue(input string sigName, input line_t actual, input line_t expected);
    assert (actual === expected) else begin
      abortRun($sformatf("CHECK FAILED at %0t: %s expected %0h got %0h",
                         $time, sigName, expected, actual));
    end
  endtask

  // one request through the cache until dataOk_o is seen
  task automatic doAccess(input logic wr, input addr_t addr, input word_t data, input mask_t mask);
    int waitCnt;
    sawRdValid = 1'b0;
    sawWrValid = 1'b0;
    waitCnt    = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    reqValid_i = 1'b1;
    reqWrite_i = wr;
    addr_i     = addr;
    wrData_i   = data;
    wrMask_i   = mask;
    @(negedge clk);
    while (!addrOk_o) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) abortRun("timeout: cache never accepted the request");
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    reqValid_i = 1'b0;
    lastCycles = 0;
    do begin
      @(negedge clk);
      lastCycles++;
      if (rdValid_o && !sawRdValid) begin
        sawRdValid = 1'b1;
        seenRdAddr = rdAddr_o;
      end
      if (wrValid_o && !sawWrValid) begin
        sawWrValid = 1'b1;
        seenWrAddr = wrAddr_o;
        seenWrLine = wrData_o;
      end
      if (lastCycles > TIMEOUT) abortRun("timeout: dataOk_o did not rise");
    end while (!dataOk_o);
    lastRdData = rdData_o;
  endtask

  task automatic readCheck(input addr_t addr);
    doAccess(1'b0, addr, '0, '0);
    checkValue("rdData_o", line_t'(lastRdData), line_t'(refMem[refIndex(addr)]));
  endtask

  task automatic storeWord(input addr_t addr, input word_t data, input mask_t mask);
    word_t bm;
    bm = expandMask(mask);
    doAccess(1'b1, addr, data, mask);
    refMem[refIndex(addr)] = (refMem[refIndex(addr)] & ~bm) | (data & bm);
  endtask

  task automatic resetStateTest;
    @(negedge clk);
    checkValue("addrOk_o", line_t'(addrOk_o), line_t'(1'b1));
    checkValue("dataOk_o", line_t'(dataOk_o), line_t'(1'b0));
    checkValue("rdValid_o", line_t'(rdValid_o), line_t'(1'b0));
    checkValue("wrValid_o", line_t'(wrValid_o), line_t'(1'b0));
  endtask

  task automatic readMissTest;
    readCheck(32'h0000_1048);
    checkValue("rdValid_o seen", line_t'(sawRdValid), line_t'(1'b1));
    checkValue("rdAddr_o", line_t'(seenRdAddr), line_t'(32'h0000_1040));
    // same line again is a hit
    readCheck(32'h0000_1058);
    checkValue("dataOk_o latency", line_t'(lastCycles), line_t'(1));
    checkValue("rdValid_o seen", line_t'(sawRdValid), line_t'(1'b0));
  endtask

  task automatic maskedStoreTest;
    storeWord(32'h0000_1050, 64'hDEAD_BEEF_0123_4567, 8'b0011_0101);
    checkValue("dataOk_o latency", line_t'(lastCycles), line_t'(1));
    readCheck(32'h0000_1050);
  endtask

  task automatic dirtyEvictTest;
    // three tags in set 3 so the third one lands on the dirty way
    storeWord(32'h0000_0068, 64'h0BAD_F00D_CAFE_1234, 8'hF0);
    readCheck(32'h0000_0860);
    checkValue("wrValid_o seen", line_t'(sawWrValid), line_t'(1'b0));
    readCheck(32'h0000_1060);
    checkValue("wrValid_o seen", line_t'(sawWrValid), line_t'(1'b1));
    checkValue("wrAddr_o", line_t'(seenWrAddr), line_t'(32'h0000_0060));
    checkValue("wrData_o", seenWrLine, refLine(32'h0000_0060));
    readCheck(32'h0000_0068);
  endtask

  task automatic randomMixTest;
    int    r;
    int    rMask;
    addr_t a;
    word_t d;
    seed = 18;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r     = $random(seed);
      rMask = $random(seed);
      d[63:32] = $random(seed);
      d[31:0]  = $random(seed);
      // four tags over sets 8 to 11
      a = {19'b0, r[1:0], 4'b0010, r[3:2], r[5:4], 3'b000};
      if (r[6]) begin
        storeWord(a, d, rMask[7:0]);
      end else begin
        readCheck(a);
      end
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    reqValid_i = 1'b0;
    reqWrite_i = 1'b0;
    addr_i     = '0;
    wrData_i   = '0;
    wrMask_i   = '0;
    // responder fills its image at time zero
    #1;
    foreach (refMem[i]) begin
      refMem[i] = i_memPort.memImage[i];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    resetStateTest();
    readMissTest();
    maskedStoreTest();
    dirtyEvictTest();
    randomMixTest();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- tbMemPort.sv
`timescale 1ns/1ps

module tbMemPort import dcachePkg::*; #(
  parameter int MEM_WORDS = 4096
) (
  input  logic  clk,
  input  logic  rdValid_i,
  input  addr_t rdAddr_i,
  input  logic  wrValid_i,
  input  addr_t wrAddr_i,
  input  line_t wrData_i,
  output logic  rdReady_o,
  output word_t memRdData_o,
  output logic  dataValid_o,
  output logic  rdLast_o,
  output logic  wrReady_o
);

  localparam int DRIVE_DELAY = 10;
  localparam int IDX_W       = $clog2(MEM_WORDS);

  word_t memImage [MEM_WORDS];
  addr_t lineAddr;
  line_t wbLine;

  // pattern built from the whole byte address
  function automatic word_t fillWord(input addr_t a);
    return {a ^ 32'hC0DE_0000, ~a + 32'h1357_9BDF};
  endfunction

  function automatic logic [IDX_W-1:0] beatIndex(input addr_t a, input wordSel_t beat);
    return {a[IDX_W+2:5], beat};
  endfunction

  initial begin
    rdReady_o   = 1'b0;
    memRdData_o = '0;
    dataValid_o = 1'b0;
    rdLast_o    = 1'b0;
    wrReady_o   = 1'b0;
    foreach (memImage[i]) begin
      memImage[i] = fillWord(addr_t'(i) << 3);
    end
    forever begin
      @(negedge clk);
      if (wrValid_i) begin
        lineAddr = wrAddr_i;
        wbLine   = wrData_i;
        // fixed two-cycle wait before taking the line
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        wrReady_o = 1'b1;
        @(posedge clk);
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
          memImage[beatIndex(lineAddr, wordSel_t'(b))] = wbLine[b*WORD_W +: WORD_W];
        end
        #DRIVE_DELAY;
        wrReady_o = 1'b0;
      end else if (rdValid_i) begin
        lineAddr = rdAddr_i;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rdReady_o = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rdReady_o = 1'b0;
        // stream the line with the last flag on the fourth beat
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
          dataValid_o = 1'b1;
          memRdData_o = memImage[beatIndex(lineAddr, wordSel_t'(b))];
          rdLast_o    = (b == BEATS_PER_LINE - 1);
          @(posedge clk);
          #DRIVE_DELAY;
        end
        dataValid_o = 1'b0;
        rdLast_o    = 1'b0;
      end
    end
  end

endmodule
